// File: vlog.f
src/cam_pkg.sv
src/reg_op_if.sv
src/cmd_sequencer.sv
src/reg_bus_master.sv
src/frame_capture.sv
src/sync_fifo.sv
src/cam_ctrl_top.sv
tests/tb_cam_ctrl.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log
verilator --binary --timing --assert -f vlog.f --top-module tb_cam_ctrl \
   -o tb_cam_ctrl > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_cam_ctrl > sim.log 2>&1
cat sim.log
grep -q "TESTS PASSED" sim.log && exit 0 || exit 1

// File: tests/tb_cam_ctrl.sv
`timescale 1ns/1ps

module tb_cam_ctrl;
   import cam_pkg::*;

   localparam int FIFO_DEPTH = 16;
   localparam int TMO        = 500; // Cycles per wait loop

   logic       bus_clk;
   logic       rst;
   logic       cmd_valid;
   logic [7:0] cmd_byte;
   logic [7:0] sw;
   logic       cmd_ready;
   logic       wb_cyc;
   logic       wb_stb;
   logic       wb_we;
   reg_addr_t  wb_adr;
   data_word_t wb_dat_w;
   logic       wb_ack;
   data_word_t wb_dat_r;
   pixel_t     pix_data;
   logic       pix_valid;
   logic       frame_start;
   logic       frame_end;
   logic       line_start;
   logic       line_end;
   logic       out_rd;
   data_word_t out_data;
   logic       out_empty;
   logic [3:0] led;

   data_word_t regs [4];     // Receiver register model
   reg_addr_t  wlog_adr [$]; // Register writes seen on the bus
   data_word_t wlog_dat [$];
   data_word_t exp_q [$];    // Expected FIFO words
   integer     seed;
   int         ack_wait;
   bit         in_cycle;
   int         wb_cycles;
   bit         drain_en;
   int         mis_exp;
   int         errors;
   int         err_mark;
   int         n_tests;
   int         n_failed;

   cam_ctrl_top #(.FIFO_DEPTH(FIFO_DEPTH), .SKIP_FRAMES(2)) dut (.*);

   initial
   begin
      bus_clk = 1'b0;
      forever #5 bus_clk = ~bus_clk;
   end

   // Wishbone slave with 0 to 3 wait cycles
   task automatic bus_model();
      int r;
      begin
         if (wb_ack)
         begin
            wb_ack   = 1'b0;
            in_cycle = 1'b0;
         end
         else if (wb_cyc && wb_stb)
         begin
            if (!in_cycle)
            begin
               in_cycle  = 1'b1;
               r         = $random(seed);
               ack_wait  = r & 3;
               wb_cycles++;
            end
            if (ack_wait == 0)
            begin
               wb_ack   = 1'b1;
               wb_dat_r = regs[wb_adr[1:0]];
               if (wb_we)
               begin
                  regs[wb_adr[1:0]] = wb_dat_w;
                  wlog_adr.push_back(wb_adr);
                  wlog_dat.push_back(wb_dat_w);
               end
            end
            else
               ack_wait--;
         end
      end
   endtask

   // Host side reader that checks every popped word
   task automatic drain_step();
      begin
         out_rd = 1'b0;
         if (drain_en && !out_empty)
         begin
            out_rd = 1'b1;
            if (exp_q.size() == 0)
            begin
               $display("FIFO returned word %h that nothing should have written", out_data);
               errors++;
            end
            else
            begin
               if (out_data !== exp_q[0])
               begin
                  $display("ERROR out_data got %h expected %h", out_data, exp_q[0]);
                  errors++;
               end
               void'(exp_q.pop_front());
            end
         end
      end
   endtask

   task automatic tick();
      begin
         @(posedge bus_clk);
         #1;
         bus_model();
         drain_step();
      end
   endtask

   task automatic abort(input string why);
      begin
         $display("%s", why);
         $display("TESTS FAILED");
         $finish;
      end
   endtask

   task automatic wait_ready();
      int t;
      begin
         t = 0;
         while (!cmd_ready && t < TMO)
         begin
            tick();
            t++;
         end
         if (!cmd_ready)
            abort("timeout, cmd_ready never came back");
      end
   endtask

   task automatic wait_writes(input int n);
      int t;
      begin
         t = 0;
         while (wlog_adr.size() < n && t < TMO)
         begin
            tick();
            t++;
         end
         if (wlog_adr.size() < n)
            abort("timeout, expected register write did not happen");
      end
   endtask

   task automatic wait_drained();
      int t;
      begin
         t = 0;
         while (exp_q.size() != 0 && t < TMO)
         begin
            tick();
            t++;
         end
         if (exp_q.size() != 0)
            abort("timeout, expected FIFO words never came out");
      end
   endtask

   task automatic send_cmd(input logic [7:0] b);
      begin
         cmd_byte  = b;
         cmd_valid = 1'b1;
         wait_ready();
         tick(); // Taken at this edge
         cmd_valid = 1'b0;
      end
   endtask

   // One frame of lines x 4 pixels
   // keep marks the frame that gets stored
   task automatic send_frame(input bit keep, input int lines, input int dup_line,
                             input int limit);
      int r;
      int l;
      int p;
      int ls;
      int le;
      int n_kept;
      begin
         ls     = 0;
         le     = 0;
         n_kept = 0;
         frame_start = 1'b1;
         tick();
         frame_start = 1'b0;
         for (l = 0; l < lines; l++)
         begin
            line_start = 1'b1;
            if (keep && ls != le)
               mis_exp++;
            ls++;
            tick();
            line_start = 1'b0;
            for (p = 0; p < 4; p++)
            begin
               if (l == dup_line && p == 2)
               begin
                  line_start = 1'b1; // Second start without an end
                  if (keep && ls != le)
                     mis_exp++;
                  ls++;
                  tick();
                  line_start = 1'b0;
               end
               r = $random(seed);
               repeat (r & 3) tick();
               r = $random(seed);
               pix_data  = r[9:0];
               pix_valid = 1'b1;
               if (keep && n_kept < limit)
               begin
                  exp_q.push_back({22'd0, r[9:0]});
                  n_kept++;
               end
               tick();
               pix_valid = 1'b0;
            end
            line_end = 1'b1;
            le++;
            tick();
            line_end = 1'b0;
         end
         frame_end = 1'b1;
         tick();
         frame_end = 1'b0;
      end
   endtask

   task automatic capture(input int lines, input int dup_line, input int limit);
      int r;
      int k;
      begin
         wlog_adr.delete();
         wlog_dat.delete();
         send_cmd(op_capture);
         wait_writes(1);
         repeat (4) tick(); // Let cap_arm settle before frames
         for (k = 0; k < 2; k++)
         begin
            send_frame(1'b0, 3, -1, 0);
            r = $random(seed);
            repeat ((r & 7) + 1) tick();
         end
         send_frame(1'b1, lines, dup_line, limit);
         wait_ready();
         if (wlog_adr.size() != 2)
         begin
            $display("capture made %0d register writes instead of 2", wlog_adr.size());
            errors++;
         end
         else
         begin
            for (k = 0; k < 2; k++)
            begin
               if (wlog_adr[k] !== REG_CTRL)
               begin
                  $display("ERROR wb_adr got %h expected %h", wlog_adr[k], REG_CTRL);
                  errors++;
               end
               if (wlog_dat[k] !== ((k == 0) ? 32'd1 : 32'd0))
               begin
                  $display("ERROR wb_dat_w got %h expected %h", wlog_dat[k],
                           (k == 0) ? 32'd1 : 32'd0);
                  errors++;
               end
            end
         end
      end
   endtask

   task automatic end_test(input string name);
      begin
         n_tests++;
         if (errors == err_mark)
            $display("test %0d %s: ok", n_tests, name);
         else
         begin
            n_failed++;
            $display("test %0d %s: %0d errors", n_tests, name, errors - err_mark);
         end
         err_mark = errors;
      end
   endtask

   initial
   begin
      int         i;
      int         r;
      int         mark;
      logic [7:0] b;
      data_word_t lane;

      seed        = 60;
      rst         = 1'b1;
      cmd_valid   = 1'b0;
      cmd_byte    = 8'h00;
      sw          = 8'h00;
      wb_ack      = 1'b0;
      wb_dat_r    = '0;
      pix_data    = '0;
      pix_valid   = 1'b0;
      frame_start = 1'b0;
      frame_end   = 1'b0;
      line_start  = 1'b0;
      line_end    = 1'b0;
      out_rd      = 1'b0;
      drain_en    = 1'b0;
      in_cycle    = 1'b0;
      ack_wait    = 0;
      wb_cycles   = 0;
      mis_exp     = 0;
      errors      = 0;
      err_mark    = 0;
      n_tests     = 0;
      n_failed    = 0;
      for (i = 0; i < 4; i++)
         regs[i] = '0;
      repeat (8) tick();
      rst = 1'b0;

      wait_ready();
      if (out_empty !== 1'b1)
      begin
         $display("ERROR out_empty got %h expected 1", out_empty);
         errors++;
      end
      if (led !== 4'h0)
      begin
         $display("ERROR led got %h expected 0", led);
         errors++;
      end
      if (wb_cyc !== 1'b0)
      begin
         $display("ERROR wb_cyc got %h expected 0", wb_cyc);
         errors++;
      end
      drain_en = 1'b1;
      mark     = wb_cycles;
      for (i = 0; i < 10; i++)
      begin
         r = $random(seed);
         b = r[7:0];
         if (b inside {8'h63, [8'h66:8'h6B]})
            b = b ^ 8'h80; // Move off the opcode range
         send_cmd(b);
      end
      repeat (4) tick();
      if (wb_cycles != mark)
      begin
         $display("unknown command byte started a Wishbone cycle");
         errors++;
      end
      if (out_empty !== 1'b1)
      begin
         $display("ERROR out_empty got %h expected 1", out_empty);
         errors++;
      end
      end_test("reset and unknown bytes");

      r  = $random(seed);
      sw = r[7:0];
      send_cmd(op_wr_cfg_one);
      wait_ready();
      if (regs[1] !== 32'd2)
      begin
         $display("ERROR REG_CFG got %h expected %h", regs[1], 32'd2);
         errors++;
      end
      send_cmd(op_wr_cfg_all);
      wait_ready();
      if (regs[1] !== 32'd3)
      begin
         $display("ERROR REG_CFG got %h expected %h", regs[1], 32'd3);
         errors++;
      end
      send_cmd(op_wr_lane);
      wait_ready();
      lane         = '0; // Inverted switches in both low byte lanes
      lane[23:16]  = ~sw;
      lane[7:0]    = ~sw;
      if (regs[2] !== lane)
      begin
         $display("ERROR REG_LANE got %h expected %h", regs[2], lane);
         errors++;
      end
      end_test("register writes");

      for (i = 0; i < 4; i++)
         regs[i] = $random(seed);
      exp_q.push_back(regs[0]);
      exp_q.push_back(regs[1]);
      exp_q.push_back(regs[2]);
      mark = wlog_adr.size();
      send_cmd(op_rd_ctrl);
      wait_ready();
      send_cmd(op_rd_cfg);
      wait_ready();
      send_cmd(op_rd_lane);
      wait_ready();
      wait_drained();
      repeat (2) tick();
      if (out_empty !== 1'b1)
      begin
         $display("ERROR out_empty got %h expected 1", out_empty);
         errors++;
      end
      if (wlog_adr.size() != mark)
      begin
         $display("register read command wrote a receiver register");
         errors++;
      end
      end_test("register reads");

      capture(3, -1, 1000);
      wait_drained();
      if (led !== 4'(mis_exp))
      begin
         $display("ERROR led got %h expected %h", led, 4'(mis_exp));
         errors++;
      end
      end_test("capture");

      capture(3, 1, 1000);
      wait_drained();
      if (led !== 4'(mis_exp))
      begin
         $display("ERROR led got %h expected %h", led, 4'(mis_exp));
         errors++;
      end
      end_test("line mismatch");

      drain_en = 1'b0; // Let the FIFO fill up
      capture(6, -1, FIFO_DEPTH);
      drain_en = 1'b1;
      wait_drained();
      repeat (3) tick();
      if (out_empty !== 1'b1)
      begin
         $display("ERROR out_empty got %h expected 1", out_empty);
         errors++;
      end
      end_test("full FIFO");

      $display("%0d tests run, %0d failed, %0d errors", n_tests, n_failed, errors);
      if (errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

// File: src/cam_ctrl_top.sv
`timescale 1ns/1ps

module cam_ctrl_top
#(
   parameter int FIFO_DEPTH  = cam_pkg::DEF_FIFO_DEPTH,
   parameter int SKIP_FRAMES = cam_pkg::DEF_SKIP_FRAMES
)
(
   input  logic                bus_clk,
   input  logic                rst,
   input  logic                cmd_valid,
   input  logic [7:0]          cmd_byte,
   input  logic [7:0]          sw,
   output logic                cmd_ready,
   output logic                wb_cyc,
   output logic                wb_stb,
   output logic                wb_we,
   output cam_pkg::reg_addr_t  wb_adr,
   output cam_pkg::data_word_t wb_dat_w,
   input  logic                wb_ack,
   input  cam_pkg::data_word_t wb_dat_r,
   input  cam_pkg::pixel_t     pix_data,
   input  logic                pix_valid,
   input  logic                frame_start,
   input  logic                frame_end,
   input  logic                line_start,
   input  logic                line_end,
   input  logic                out_rd,
   output cam_pkg::data_word_t out_data,
   output logic                out_empty,
   output logic [3:0]          led
);
   import cam_pkg::*;

   logic       cap_arm;
   logic       cap_done;
   logic       rd_push;
   data_word_t rd_word;
   logic       wr_en;
   data_word_t wr_data;
   logic       full;

   reg_op_if reg_op ();

   cmd_sequencer u_seq (
      .bus_clk   (bus_clk),
      .rst       (rst),
      .cmd_valid (cmd_valid),
      .cmd_byte  (cmd_byte),
      .sw        (sw),
      .cap_done  (cap_done),
      .cmd_ready (cmd_ready),
      .cap_arm   (cap_arm),
      .rd_push   (rd_push),
      .rd_word   (rd_word),
      .reg_op    (reg_op)
   );

   reg_bus_master u_wb (
      .bus_clk  (bus_clk),
      .rst      (rst),
      .wb_ack   (wb_ack),
      .wb_dat_r (wb_dat_r),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .reg_op   (reg_op)
   );

   frame_capture #(.SKIP_FRAMES(SKIP_FRAMES)) u_cap (
      .bus_clk     (bus_clk),
      .rst         (rst),
      .cap_arm     (cap_arm),
      .pix_data    (pix_data),
      .pix_valid   (pix_valid),
      .frame_start (frame_start),
      .frame_end   (frame_end),
      .line_start  (line_start),
      .line_end    (line_end),
      .rd_push     (rd_push),
      .rd_word     (rd_word),
      .full        (full),
      .cap_done    (cap_done),
      .wr_en       (wr_en),
      .wr_data     (wr_data),
      .led         (led)
   );

   sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .WIDTH($bits(data_word_t))) u_fifo (
      .bus_clk (bus_clk),
      .rst     (rst),
      .wr_en   (wr_en),
      .wr_data (wr_data),
      .rd_en   (out_rd),
      .rd_data (out_data),
      .empty   (out_empty),
      .full    (full)
   );

endmodule

// File: src/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo
#(
   parameter int FIFO_DEPTH = cam_pkg::DEF_FIFO_DEPTH,
   parameter int WIDTH      = 32
)
(
   input  logic             bus_clk,
   input  logic             rst,
   input  logic             wr_en,
   input  logic [WIDTH-1:0] wr_data,
   input  logic             rd_en,
   output logic [WIDTH-1:0] rd_data,
   output logic             empty,
   output logic             full
);

   localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CW = $clog2(FIFO_DEPTH + 1);

   logic [WIDTH-1:0] mem [FIFO_DEPTH];
   logic [AW-1:0]    wr_ptr;
   logic [AW-1:0]    rd_ptr;
   logic [CW-1:0]    count;
   logic             do_wr;
   logic             do_rd;

   function automatic logic [AW-1:0] bump(input logic [AW-1:0] ptr);
      if (ptr == AW'(FIFO_DEPTH - 1))
         return '0; // Wrap for non power of two depths
      return ptr + 1'b1;
   endfunction

   assign do_wr   = wr_en && !full;
   assign do_rd   = rd_en && !empty;
   assign full    = (count == CW'(FIFO_DEPTH));
   assign empty   = (count == '0);
   assign rd_data = mem[rd_ptr]; // Show-ahead head

   always_ff @(posedge bus_clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= bump(wr_ptr);
         if (do_rd)
            rd_ptr <= bump(rd_ptr);
         if (do_wr && !do_rd)
            count <= count + 1'b1;
         else if (do_rd && !do_wr)
            count <= count - 1'b1;
      end
   end

   always_ff @(posedge bus_clk)
   begin
      if (do_wr)
         mem[wr_ptr] <= wr_data;
   end

   a_count_bound: assert property (@(posedge bus_clk) disable iff (rst)
      count <= CW'(FIFO_DEPTH));

endmodule

// File: src/frame_capture.sv
`timescale 1ns/1ps

module frame_capture
#(
   parameter int SKIP_FRAMES = cam_pkg::DEF_SKIP_FRAMES
)
(
   input  logic                bus_clk,
   input  logic                rst,
   input  logic                cap_arm,
   input  cam_pkg::pixel_t     pix_data,
   input  logic                pix_valid,
   input  logic                frame_start,
   input  logic                frame_end,
   input  logic                line_start,
   input  logic                line_end,
   input  logic                rd_push,
   input  cam_pkg::data_word_t rd_word,
   input  logic                full,
   output logic                cap_done,
   output logic                wr_en,
   output cam_pkg::data_word_t wr_data,
   output logic [3:0]          led
);
   import cam_pkg::*;

   localparam int SKIP_W = $clog2(SKIP_FRAMES + 2);

   typedef enum logic [1:0] {cap_idle, cap_skip, cap_open, cap_closed} cap_state_t;

   cap_state_t        state;
   logic [SKIP_W-1:0] skip_cnt;
   logic [15:0]       ls_cnt;
   logic [15:0]       le_cnt;
   logic [3:0]        mis_cnt;
   logic              pix_wr;

   // Closing frame_end cycle is not stored
   assign pix_wr   = (state == cap_open) && pix_valid && !frame_end;
   assign cap_done = (state == cap_open) && frame_end;
   assign wr_en    = (pix_wr || rd_push) && !full;
   assign wr_data  = rd_push ? rd_word : data_word_t'(pix_data);
   assign led      = mis_cnt;

   always_ff @(posedge bus_clk)
   begin
      if (rst || !cap_arm)
      begin
         state    <= cap_idle;
         skip_cnt <= '0;
      end
      else
      begin
         case (state)
            cap_idle:
               state <= cap_skip;
            cap_skip:
            begin
               if (skip_cnt == SKIP_W'(SKIP_FRAMES))
               begin
                  if (frame_start)
                     state <= cap_open;
               end
               else if (frame_end)
                  skip_cnt <= skip_cnt + 1'b1;
            end
            cap_open:
               if (frame_end)
                  state <= cap_closed;
            default:
               state <= cap_closed; // Hold until cap_arm drops
         endcase
      end
   end

   // Line bookkeeping, a line_start before the last line_end counts as mismatch
   always_ff @(posedge bus_clk)
   begin
      if (rst)
      begin
         ls_cnt  <= '0;
         le_cnt  <= '0;
         mis_cnt <= '0;
      end
      else if (state == cap_skip && skip_cnt == SKIP_W'(SKIP_FRAMES) && frame_start)
      begin
         ls_cnt <= '0;
         le_cnt <= '0;
      end
      else if (state == cap_open)
      begin
         if (line_start)
         begin
            if (ls_cnt != le_cnt)
               mis_cnt <= mis_cnt + 1'b1;
            ls_cnt <= ls_cnt + 1'b1;
         end
         if (line_end)
            le_cnt <= le_cnt + 1'b1;
      end
   end

   // Register reads and pixels must never compete for the FIFO
   a_no_push_in_capture: assert property (@(posedge bus_clk) disable iff (rst)
      !(rd_push && state == cap_open));

endmodule

// File: src/reg_bus_master.sv
`timescale 1ns/1ps

module reg_bus_master
(
   input  logic                bus_clk,
   input  logic                rst,
   input  logic                wb_ack,
   input  cam_pkg::data_word_t wb_dat_r,
   output logic                wb_cyc,
   output logic                wb_stb,
   output logic                wb_we,
   output cam_pkg::reg_addr_t  wb_adr,
   output cam_pkg::data_word_t wb_dat_w,
   reg_op_if.master            reg_op
);

   typedef enum logic {bus_idle, bus_wait_ack} bus_state_t;

   bus_state_t state;
   logic       launch;

   // done still high means req is about to drop, no relaunch
   assign launch = (state == bus_idle) && reg_op.req && !reg_op.done;

   always_ff @(posedge bus_clk)
   begin
      if (rst)
      begin
         state       <= bus_idle;
         wb_cyc      <= 1'b0;
         wb_stb      <= 1'b0;
         reg_op.done <= 1'b0;
      end
      else
      begin
         reg_op.done <= 1'b0;
         if (launch)
         begin
            state  <= bus_wait_ack;
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
         end
         else if (state == bus_wait_ack && wb_ack)
         begin
            state       <= bus_idle;
            wb_cyc      <= 1'b0;
            wb_stb      <= 1'b0;
            reg_op.done <= 1'b1;
         end
      end
   end

   always_ff @(posedge bus_clk)
   begin
      if (launch)
      begin
         wb_we    <= reg_op.we;
         wb_adr   <= reg_op.adr;
         wb_dat_w <= reg_op.wdata;
      end
      if (state == bus_wait_ack && wb_ack)
         reg_op.rdata <= wb_dat_r; // Captured with the ack
   end

   a_stb_in_cyc: assert property (@(posedge bus_clk) disable iff (rst)
      wb_stb |-> wb_cyc);

endmodule

// File: src/cmd_sequencer.sv
`timescale 1ns/1ps

module cmd_sequencer
(
   input  logic                bus_clk,
   input  logic                rst,
   input  logic                cmd_valid,
   input  logic [7:0]          cmd_byte,
   input  logic [7:0]          sw,
   input  logic                cap_done,
   output logic                cmd_ready,
   output logic                cap_arm,
   output logic                rd_push,
   output cam_pkg::data_word_t rd_word,
   reg_op_if.seq               reg_op
);
   import cam_pkg::*;

   seq_state_t state;
   cmd_op_t    op;
   logic       is_read;
   logic       take;

   assign op   = cmd_op_t'(cmd_byte);
   assign take = (state == st_idle) && cmd_valid && cmd_ready;

   always_ff @(posedge bus_clk)
   begin
      if (rst)
      begin
         state      <= st_idle;
         cmd_ready  <= 1'b0;
         cap_arm    <= 1'b0;
         rd_push    <= 1'b0;
         reg_op.req <= 1'b0;
      end
      else
      begin
         rd_push <= 1'b0;
         case (state)
            st_idle:
            begin
               cmd_ready <= 1'b1;
               if (take)
               begin
                  case (op)
                     op_rd_ctrl, op_rd_cfg, op_rd_lane,
                     op_wr_cfg_one, op_wr_cfg_all, op_wr_lane:
                     begin
                        cmd_ready  <= 1'b0;
                        reg_op.req <= 1'b1;
                        state      <= st_reg_op;
                     end
                     op_capture:
                     begin
                        cmd_ready  <= 1'b0;
                        reg_op.req <= 1'b1; // Enable write first
                        state      <= st_cap_enable;
                     end
                     default:
                     begin
                        state <= st_idle; // Unknown byte, dropped
                     end
                  endcase
               end
            end
            st_reg_op:
            begin
               if (reg_op.done)
               begin
                  reg_op.req <= 1'b0;
                  if (is_read)
                  begin
                     rd_push <= 1'b1;
                     state   <= st_push_read;
                  end
                  else
                  begin
                     cmd_ready <= 1'b1;
                     state     <= st_idle;
                  end
               end
            end
            st_push_read:
            begin
               cmd_ready <= 1'b1;
               state     <= st_idle;
            end
            st_cap_enable:
            begin
               if (reg_op.done)
               begin
                  reg_op.req <= 1'b0;
                  cap_arm    <= 1'b1;
                  state      <= st_capturing;
               end
            end
            st_capturing:
            begin
               if (cap_done)
               begin
                  cap_arm    <= 1'b0;
                  reg_op.req <= 1'b1; // Disable write
                  state      <= st_cap_disable;
               end
            end
            st_cap_disable:
            begin
               if (reg_op.done)
               begin
                  reg_op.req <= 1'b0;
                  cmd_ready  <= 1'b1;
                  state      <= st_idle;
               end
            end
            default:
            begin
               state <= st_idle;
            end
         endcase
      end
   end

   // Operation payload, stable while req is up
   always_ff @(posedge bus_clk)
   begin
      if (take)
      begin
         is_read      <= 1'b0;
         reg_op.we    <= 1'b1;
         reg_op.wdata <= '0;
         case (op)
            op_rd_ctrl:
            begin
               reg_op.adr <= REG_CTRL;
               reg_op.we  <= 1'b0;
               is_read    <= 1'b1;
            end
            op_rd_cfg:
            begin
               reg_op.adr <= REG_CFG;
               reg_op.we  <= 1'b0;
               is_read    <= 1'b1;
            end
            op_rd_lane:
            begin
               reg_op.adr <= REG_LANE;
               reg_op.we  <= 1'b0;
               is_read    <= 1'b1;
            end
            op_wr_cfg_one:
            begin
               reg_op.adr   <= REG_CFG;
               reg_op.wdata <= 32'd2;
            end
            op_wr_cfg_all:
            begin
               reg_op.adr   <= REG_CFG;
               reg_op.wdata <= 32'd3;
            end
            op_wr_lane:
            begin
               reg_op.adr   <= REG_LANE;
               reg_op.wdata <= {8'h00, ~sw, 8'h00, ~sw};
            end
            default:
            begin
               reg_op.adr   <= REG_CTRL; // Enable for capture
               reg_op.wdata <= 32'd1;
            end
         endcase
      end
      else if (state == st_capturing && cap_done)
      begin
         reg_op.adr   <= REG_CTRL;
         reg_op.we    <= 1'b1;
         reg_op.wdata <= '0;
      end
      if (state == st_reg_op && reg_op.done)
         rd_word <= reg_op.rdata;
   end

   // Host may only hand over a byte while nothing is in flight
   a_ready_idle: assert property (@(posedge bus_clk) disable iff (rst)
      cmd_ready |-> (state == st_idle && !reg_op.req && !cap_arm));

endmodule

// File: src/reg_op_if.sv
`timescale 1ns/1ps

// One register access, sequencer to bus master
interface reg_op_if;
   import cam_pkg::*;

   logic       req;
   logic       we;
   reg_addr_t  adr;
   data_word_t wdata;
   data_word_t rdata;
   logic       done;   // Single-cycle pulse

   modport seq (output req, we, adr, wdata, input rdata, done);

   modport master (input req, we, adr, wdata, output rdata, done);

endinterface

// File: src/cam_pkg.sv
package cam_pkg;

   // Sequencer states
   typedef enum logic [4:0] {
      st_idle,
      st_reg_op,
      st_push_read,
      st_cap_enable,
      st_capturing,
      st_cap_disable
   } seq_state_t;

   // Host command bytes
   typedef enum logic [7:0] {
      op_capture    = 8'h63,
      op_rd_ctrl    = 8'h66, // Reads REG_CTRL
      op_rd_cfg     = 8'h67, // Reads REG_CFG
      op_wr_cfg_one = 8'h68, // Writes 2 to REG_CFG
      op_wr_cfg_all = 8'h69, // Writes 3 to REG_CFG
      op_rd_lane    = 8'h6A, // Reads REG_LANE
      op_wr_lane    = 8'h6B  // Inverted switches into REG_LANE
   } cmd_op_t;

   typedef logic [5:0]  reg_addr_t;  // Receiver word address
   typedef logic [31:0] data_word_t;
   typedef logic [9:0]  pixel_t;     // RAW10

   localparam reg_addr_t REG_CTRL = 6'd0; // Bit 0 enables the receiver
   localparam reg_addr_t REG_CFG  = 6'd1;
   localparam reg_addr_t REG_LANE = 6'd2;

   localparam int DEF_FIFO_DEPTH  = 16;
   localparam int DEF_SKIP_FRAMES = 2;

endpackage
